// ==== hdl/apb_param_table.sv ====
`include "glay_cfg_defines.svh"

module apb_param_table (
    input  logic                       ap_clk,
    input  logic                       areset,
    input  logic [11:0]                paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output glay_cfg_pkg::param_table_t table_out
);

    // span of all slot register pairs
    localparam int SLOT_SPAN = `GLAY_NUM_SLOTS * `GLAY_REG_STRIDE;
    localparam int META_W    = $bits(glay_cfg_pkg::slot_meta_t);
    localparam int N         = `GLAY_NUM_SLOTS;

    glay_cfg_pkg::param_table_t table_q;

    logic [`GLAY_SLOT_ID_W-1:0] slot_idx;
    logic                       in_slots;
    logic                       hit_param;
    logic                       hit_meta;
    logic                       hit_mask;
    logic                       wr_en;

    // ------------------------------
    // address decode
    // ------------------------------
    // slot index from the pair number
    assign slot_idx  = `GLAY_SLOT_ID_W'(paddr / `GLAY_REG_STRIDE);
    assign in_slots  = paddr < 12'(SLOT_SPAN);
    // param at pair offset 0
    assign hit_param = in_slots && ((paddr % `GLAY_REG_STRIDE) == 0);
    // meta at pair offset 4
    assign hit_meta  = in_slots && ((paddr % `GLAY_REG_STRIDE) == 4);
    assign hit_mask  = paddr == `GLAY_MASK_ADDR;

    // write lands on the access phase edge
    assign wr_en = psel && penable && pwrite;

    // no wait states
    assign pready = 1'b1;

    // ------------------------------
    // table registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            table_q <= '0;
        end else if (wr_en) begin
            if (hit_param) begin
                table_q.param[slot_idx] <= pwdata;
            end
            if (hit_meta) begin
                // low bits only, upper bits of the word are dropped
                table_q.meta[slot_idx] <= glay_cfg_pkg::slot_meta_t'(pwdata[META_W-1:0]);
            end
            if (hit_mask) begin
                table_q.cast_mask <= pwdata[N-1:0];
                table_q.lane_mask <= pwdata[2*N-1:N];
            end
        end
    end

    // selector sees the table every cycle
    assign table_out = table_q;

    // ------------------------------
    // readback
    // ------------------------------
    always_comb begin
        prdata = '0;
        // setup and access phase both drive, sampled in access
        if (psel && !pwrite) begin
            if (hit_param) begin
                prdata = table_q.param[slot_idx];
            end else if (hit_meta) begin
                prdata = 32'(table_q.meta[slot_idx]);
            end else if (hit_mask) begin
                prdata = {16'h0000, table_q.lane_mask, table_q.cast_mask};
            end
            // anything else reads back as zero
        end
    end

endmodule

// ==== hdl/config_params_select_pulse.sv ====
`include "glay_cfg_defines.svh"

module config_params_select_pulse (
    input  logic                           ap_clk,
    input  logic                           areset,
    input  glay_cfg_pkg::param_table_t     table_in,
    input  glay_cfg_pkg::engine_response_t response_in,
    output logic                           response_ready,
    output logic                           busy_pulse,
    output glay_cfg_pkg::config_delivery_t delivery_out
);

    localparam int N = `GLAY_NUM_SLOTS;

    glay_cfg_pkg::select_state_e state_q;

    logic [N-1:0]               cast_hit;
    logic [N-1:0]               lane_hit;
    logic [N-1:0]               match;
    logic [N-1:0]               pending_q;
    logic [N-1:0]               pending_rest;
    logic [`GLAY_SLOT_ID_W-1:0] issue_idx;
    logic                       accept;
    logic                       issue_valid;

    // ------------------------------
    // slot match
    // ------------------------------
    // ids must agree, then either mask makes the slot eligible
    always_comb begin
        cast_hit = '0;
        lane_hit = '0;
        for (int i = 0; i < N; i++) begin
            if ((table_in.meta[i].bundle_id == response_in.bundle_id) &&
                (table_in.meta[i].lane_id == response_in.lane_id)) begin
                cast_hit[i] = table_in.cast_mask[i];
                lane_hit[i] = table_in.lane_mask[i];
            end
        end
    end

    assign match = cast_hit | lane_hit;

    // only take a response between bursts
    assign response_ready = state_q == glay_cfg_pkg::SEL_IDLE;
    assign accept         = response_in.valid && response_ready;

    // ------------------------------
    // issue order
    // ------------------------------
    // lowest pending slot wins, scan from the top down
    always_comb begin
        issue_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                issue_idx = `GLAY_SLOT_ID_W'(i);
            end
        end
    end

    // drop the lowest set bit
    assign pending_rest = pending_q & (pending_q - 1'b1);

    // ------------------------------
    // fsm
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state_q   <= glay_cfg_pkg::SEL_IDLE;
            pending_q <= '0;
        end else begin
            case (state_q)
                glay_cfg_pkg::SEL_IDLE: begin
                    // empty match set leaves us idle, no busy cycle
                    if (accept && (|match)) begin
                        pending_q <= match;
                        state_q   <= glay_cfg_pkg::SEL_ISSUE;
                    end
                end
                glay_cfg_pkg::SEL_ISSUE: begin
                    pending_q <= pending_rest;
                    // last slot out this cycle
                    if (pending_rest == '0) begin
                        state_q <= glay_cfg_pkg::SEL_IDLE;
                    end
                end
                default: begin
                    state_q <= glay_cfg_pkg::SEL_IDLE;
                end
            endcase
        end
    end

    // pending is never empty in issue, so the state alone marks a delivery
    assign issue_valid = state_q == glay_cfg_pkg::SEL_ISSUE;
    // busy while matched slots are still pending
    assign busy_pulse  = |pending_q;

    always_comb begin
        delivery_out.valid = issue_valid;
        delivery_out.slot  = issue_idx;
        delivery_out.param = table_in.param[issue_idx];
        delivery_out.op    = table_in.meta[issue_idx].op;
    end

endmodule

// ==== hdl/glay_cfg_defines.svh ====
`ifndef GLAY_CFG_DEFINES_SVH
`define GLAY_CFG_DEFINES_SVH

// ------------------------------
// slot table geometry
// ------------------------------
// one slot per kernel
`define GLAY_NUM_SLOTS 8
// log2 of the slot count
`define GLAY_SLOT_ID_W 3

// ------------------------------
// data and routing widths
// ------------------------------
// parameter word and operand width
`define GLAY_DATA_W 32
// bundle id and lane id width
`define GLAY_ID_W 4

// ------------------------------
// apb register map
// ------------------------------
// slot pair spacing, param at +0, meta at +4
`define GLAY_REG_STRIDE 8
// cast mask in byte 0, lane mask in byte 1
`define GLAY_MASK_ADDR 12'h100

`endif

// ==== hdl/glay_cfg_pkg.sv ====
`include "glay_cfg_defines.svh"

package glay_cfg_pkg;

    // ------------------------------
    // enums
    // ------------------------------
    // kernel opcode, zero must stay add so a fresh kernel passes data through
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MIN = 2'd2,
        OP_MAX = 2'd3
    } kernel_op_e;

    // selector fsm
    typedef enum logic {
        SEL_IDLE  = 1'b0,
        SEL_ISSUE = 1'b1
    } select_state_e;

    // ------------------------------
    // table types
    // ------------------------------
    // meta register bits [9:0], bundle on top, opcode at the bottom
    typedef struct packed {
        logic [`GLAY_ID_W-1:0] bundle_id;
        logic [`GLAY_ID_W-1:0] lane_id;
        kernel_op_e            op;
    } slot_meta_t;

    // whole table, table to selector every cycle
    typedef struct packed {
        logic [`GLAY_NUM_SLOTS-1:0][`GLAY_DATA_W-1:0] param;
        slot_meta_t [`GLAY_NUM_SLOTS-1:0]             meta;
        logic [`GLAY_NUM_SLOTS-1:0]                   cast_mask;
        logic [`GLAY_NUM_SLOTS-1:0]                   lane_mask;
    } param_table_t;

    // ------------------------------
    // streams
    // ------------------------------
    // engine response, only routing ids matter here
    typedef struct packed {
        logic                  valid;
        logic [`GLAY_ID_W-1:0] bundle_id;
        logic [`GLAY_ID_W-1:0] lane_id;
    } engine_response_t;

    // one slot handed to its kernel
    typedef struct packed {
        logic                       valid;
        logic [`GLAY_SLOT_ID_W-1:0] slot;
        logic [`GLAY_DATA_W-1:0]    param;
        kernel_op_e                 op;
    } config_delivery_t;

    // operand broadcast to all kernels
    typedef struct packed {
        logic                       valid;
        logic [`GLAY_SLOT_ID_W-1:0] kernel;
        logic [`GLAY_DATA_W-1:0]    operand;
    } data_packet_t;

    // kernel output, also the collector output
    typedef struct packed {
        logic                       valid;
        logic [`GLAY_SLOT_ID_W-1:0] kernel;
        logic [`GLAY_DATA_W-1:0]    value;
    } kernel_result_t;

endpackage

// ==== hdl/glay_cfg_top.sv ====
`include "glay_cfg_defines.svh"

module glay_cfg_top (
    input  logic                           ap_clk,
    input  logic                           areset,
    input  logic [11:0]                    paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    input  glay_cfg_pkg::engine_response_t response_in,
    output logic                           response_ready,
    output logic                           busy_pulse,
    output glay_cfg_pkg::config_delivery_t delivery_out,
    input  glay_cfg_pkg::data_packet_t     data_in,
    output glay_cfg_pkg::kernel_result_t   result_out
);

    glay_cfg_pkg::param_table_t   table_w;
    glay_cfg_pkg::kernel_result_t kernel_results [`GLAY_NUM_SLOTS];

    // ------------------------------
    // config path
    // ------------------------------
    apb_param_table u_table (
        .ap_clk   (ap_clk),
        .areset   (areset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .table_out(table_w)
    );

    // response match and slot issue
    config_params_select_pulse u_select (
        .ap_clk        (ap_clk),
        .areset        (areset),
        .table_in      (table_w),
        .response_in   (response_in),
        .response_ready(response_ready),
        .busy_pulse    (busy_pulse),
        .delivery_out  (delivery_out)
    );

    // ------------------------------
    // kernel array
    // ------------------------------
    // deliveries and operands go to every kernel, each filters its own id
    for (genvar g = 0; g < `GLAY_NUM_SLOTS; g++) begin : g_kernel
        param_kernel #(
            .KERNEL_ID(g)
        ) u_kernel (
            .ap_clk     (ap_clk),
            .areset     (areset),
            .delivery_in(delivery_out),
            .data_in    (data_in),
            .result_out (kernel_results[g])
        );
    end

    // merge to one stream, second pipeline stage
    kernel_result_collect u_collect (
        .ap_clk    (ap_clk),
        .areset    (areset),
        .results_in(kernel_results),
        .result_out(result_out)
    );

endmodule

// ==== hdl/kernel_result_collect.sv ====
`include "glay_cfg_defines.svh"

module kernel_result_collect (
    input  logic                         ap_clk,
    input  logic                         areset,
    input  glay_cfg_pkg::kernel_result_t results_in [`GLAY_NUM_SLOTS],
    output glay_cfg_pkg::kernel_result_t result_out
);

    glay_cfg_pkg::kernel_result_t merged;
    glay_cfg_pkg::kernel_result_t result_q;

    // ------------------------------
    // one-hot merge
    // ------------------------------
    // invalid entries masked off, at most one survives
    always_comb begin
        merged = '0;
        for (int i = 0; i < `GLAY_NUM_SLOTS; i++) begin
            if (results_in[i].valid) begin
                merged = glay_cfg_pkg::kernel_result_t'(merged | results_in[i]);
            end
        end
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            result_q.valid <= 1'b0;
        end else begin
            result_q.valid <= merged.valid;
        end
    end

    // payload follows, kept in step with valid
    always_ff @(posedge ap_clk) begin
        result_q.kernel <= merged.kernel;
        result_q.value  <= merged.value;
    end

    assign result_out = result_q;

endmodule

// ==== hdl/param_kernel.sv ====
`include "glay_cfg_defines.svh"

module param_kernel #(
    parameter int KERNEL_ID = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset,
    input  glay_cfg_pkg::config_delivery_t delivery_in,
    input  glay_cfg_pkg::data_packet_t     data_in,
    output glay_cfg_pkg::kernel_result_t   result_out
);

    localparam logic [`GLAY_SLOT_ID_W-1:0] MY_ID = `GLAY_SLOT_ID_W'(KERNEL_ID);

    logic [`GLAY_DATA_W-1:0] param_q;
    glay_cfg_pkg::kernel_op_e op_q;
    logic [`GLAY_DATA_W-1:0] compute;
    logic [`GLAY_DATA_W-1:0] value_q;
    logic                    valid_q;

    // ------------------------------
    // config latch
    // ------------------------------
    // zero param with add opcode means plain pass through
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            param_q <= '0;
            op_q    <= glay_cfg_pkg::OP_ADD;
        end else if (delivery_in.valid && (delivery_in.slot == MY_ID)) begin
            param_q <= delivery_in.param;
            op_q    <= delivery_in.op;
        end
    end

    // ------------------------------
    // datapath
    // ------------------------------
    always_comb begin
        case (op_q)
            glay_cfg_pkg::OP_ADD: compute = data_in.operand + param_q;
            glay_cfg_pkg::OP_SUB: compute = data_in.operand - param_q;
            // unsigned compare for min and max
            glay_cfg_pkg::OP_MIN: compute = (data_in.operand < param_q) ? data_in.operand : param_q;
            glay_cfg_pkg::OP_MAX: compute = (data_in.operand > param_q) ? data_in.operand : param_q;
            default:              compute = data_in.operand;
        endcase
    end

    // result one cycle after the operand
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= data_in.valid && (data_in.kernel == MY_ID);
        end
    end

    always_ff @(posedge ap_clk) begin
        value_q <= compute;
    end

    assign result_out.valid  = valid_q;
    assign result_out.kernel = MY_ID;
    assign result_out.value  = value_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

# build the testbench together with the rtl and the bound assertions
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module glay_cfg_tb -f sources.f -o glay_cfg_sim

# a failing assertion stops the simulator with a nonzero status
./obj_dir/glay_cfg_sim 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished cleanly"

// ==== sources.f ====
+incdir+hdl
hdl/glay_cfg_pkg.sv
hdl/apb_param_table.sv
hdl/config_params_select_pulse.sv
hdl/param_kernel.sv
hdl/kernel_result_collect.sv
hdl/glay_cfg_top.sv
verification/glay_cfg_sva.sv
verification/glay_cfg_tb.sv

// ==== verification/glay_cfg_sva.sv ====
module glay_cfg_sva (
    input logic                           ap_clk,
    input logic                           areset,
    input logic                           response_ready,
    input logic                           busy_pulse,
    input glay_cfg_pkg::config_delivery_t delivery_out,
    input glay_cfg_pkg::data_packet_t     data_in,
    input glay_cfg_pkg::kernel_result_t   result_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------
    // selector
    // ------------------------------
    busy_is_delivery: assert property (@(posedge ap_clk) disable iff (areset)
        busy_pulse == delivery_out.valid)
        else $error("busy_pulse and delivery valid disagree");

    // held off while a burst is out
    no_ready_in_burst: assert property (@(posedge ap_clk) disable iff (areset)
        busy_pulse |-> !response_ready)
        else $error("response_ready high during a burst");

    slot_ascending: assert property (@(posedge ap_clk) disable iff (areset)
        (busy_pulse && $past(busy_pulse)) |-> (delivery_out.slot > $past(delivery_out.slot)))
        else $error("slot index did not increase within a burst");

    // ------------------------------
    // kernel path, two register stages
    // ------------------------------
    result_two_later: assert property (@(posedge ap_clk) disable iff (areset)
        $past(data_in.valid, 2) |->
            (result_out.valid && result_out.kernel == $past(data_in.kernel, 2)))
        else $error("no result two cycles after a data packet");

endmodule

bind glay_cfg_top glay_cfg_sva u_sva (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .response_ready(response_ready),
    .busy_pulse    (busy_pulse),
    .delivery_out  (delivery_out),
    .data_in       (data_in),
    .result_out    (result_out)
);

// ==== verification/glay_cfg_tb.sv ====
`include "glay_cfg_defines.svh"

module glay_cfg_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N       = `GLAY_NUM_SLOTS;
    localparam int SPAN    = `GLAY_NUM_SLOTS * `GLAY_REG_STRIDE;
    localparam int TIMEOUT = 200;

    typedef enum logic [1:0] {
        ROW_WR,
        ROW_RD,
        ROW_RESP,
        ROW_DATA
    } row_kind_e;

    // addr carries {bundle, lane} for responses and the kernel index for data
    typedef struct packed {
        row_kind_e   kind;
        logic [11:0] addr;
        logic [31:0] data;
        logic [3:0]  exp_cnt;
        logic        hold;
    } row_t;

    typedef struct packed {
        logic [2:0]  slot;
        logic [31:0] param;
        logic [1:0]  op;
        logic        last;
    } deliv_exp_t;

    typedef struct packed {
        logic [2:0]  kernel;
        logic [31:0] value;
        logic [31:0] due;
    } result_exp_t;

    logic                           ap_clk;
    logic                           areset;
    logic [11:0]                    paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [31:0]                    pwdata;
    logic [31:0]                    prdata;
    logic                           pready;
    glay_cfg_pkg::engine_response_t response_in;
    logic                           response_ready;
    logic                           busy_pulse;
    glay_cfg_pkg::config_delivery_t delivery_out;
    glay_cfg_pkg::data_packet_t     data_in;
    glay_cfg_pkg::kernel_result_t   result_out;

    // ------------------------------
    // reference model state
    // ------------------------------
    logic [31:0] cfg_param [N];
    logic [9:0]  cfg_meta  [N];
    logic [31:0] m_param   [N];
    logic [9:0]  m_meta    [N];
    logic [7:0]  m_cast;
    logic [7:0]  m_lane;
    logic [31:0] k_param   [N];
    logic [1:0]  k_op      [N];
    row_t        rows      [$];
    deliv_exp_t  exp_deliv [$];
    result_exp_t exp_res   [$];
    logic [31:0] cyc       = '0;
    logic [31:0] burst_cyc = '1;
    logic        more_due;
    int          errors;
    int          checks;
    int          timeouts;
    integer      seed;

    glay_cfg_top UUT (.*);

    always #20 ap_clk = ~ap_clk;

    // rising edge count, stable at every falling edge
    always @(posedge ap_clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t ns: gave up waiting for %s", $time, what);
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        logic [31:0] val;
        val = '0;
        if (addr < SPAN && addr % `GLAY_REG_STRIDE == 0) begin
            val = m_param[addr / `GLAY_REG_STRIDE];
        end else if (addr < SPAN && addr % `GLAY_REG_STRIDE == 4) begin
            val = 32'(m_meta[addr / `GLAY_REG_STRIDE]);
        end else if (addr == `GLAY_MASK_ADDR) begin
            val = {16'h0000, m_lane, m_cast};
        end
        return val;
    endfunction

    function automatic void model_write(input logic [11:0] addr, input logic [31:0] data);
        if (addr < SPAN && addr % `GLAY_REG_STRIDE == 0) begin
            m_param[addr / `GLAY_REG_STRIDE] = data;
        end else if (addr < SPAN && addr % `GLAY_REG_STRIDE == 4) begin
            // meta keeps only bundle, lane and opcode
            m_meta[addr / `GLAY_REG_STRIDE] = data[9:0];
        end else if (addr == `GLAY_MASK_ADDR) begin
            m_cast = data[7:0];
            m_lane = data[15:8];
        end
    endfunction

    function automatic logic [31:0] kernel_calc(input logic [1:0] op, input logic [31:0] a,
                                                input logic [31:0] p);
        case (op)
            glay_cfg_pkg::OP_ADD: return a + p;
            glay_cfg_pkg::OP_SUB: return a - p;
            glay_cfg_pkg::OP_MIN: return (a < p) ? a : p;
            default:              return (a > p) ? a : p;
        endcase
    endfunction

    // queue the expected deliveries, lowest slot first
    function automatic int predict_matches(input logic [3:0] bundle, input logic [3:0] lane);
        logic [N-1:0] hit;
        deliv_exp_t   e;
        int           cnt;
        hit = '0;
        cnt = 0;
        for (int i = 0; i < N; i++) begin
            if (m_meta[i][9:6] == bundle && m_meta[i][5:2] == lane && (m_cast[i] || m_lane[i])) begin
                hit[i] = 1'b1;
            end
        end
        for (int i = 0; i < N; i++) begin
            if (hit[i]) begin
                cnt++;
                e.slot  = 3'(i);
                e.param = m_param[i];
                e.op    = m_meta[i][1:0];
                e.last  = (hit >> (i + 1)) == '0;
                exp_deliv.push_back(e);
            end
        end
        return cnt;
    endfunction

    task automatic add_row(input row_kind_e kind, input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] cnt, input logic hold);
        row_t r;
        r.kind    = kind;
        r.addr    = addr;
        r.data    = data;
        r.exp_cnt = cnt;
        r.hold    = hold;
        rows.push_back(r);
    endtask

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic build_rows();
        for (int i = 0; i < N; i++) begin
            add_row(ROW_WR, 12'(i * `GLAY_REG_STRIDE), cfg_param[i], 4'd0, 1'b0);
            add_row(ROW_WR, 12'(i * `GLAY_REG_STRIDE + 4), 32'(cfg_meta[i]), 4'd0, 1'b0);
        end
        // cast 0x4d, lane 0x1a, top half of the word is dropped
        add_row(ROW_WR, `GLAY_MASK_ADDR, 32'hdead_1a4d, 4'd0, 1'b0);
        for (int i = 0; i < N; i++) begin
            add_row(ROW_RD, 12'(i * `GLAY_REG_STRIDE), 32'd0, 4'd0, 1'b0);
            add_row(ROW_RD, 12'(i * `GLAY_REG_STRIDE + 4), 32'd0, 4'd0, 1'b0);
        end
        add_row(ROW_RD, `GLAY_MASK_ADDR, 32'd0, 4'd0, 1'b0);
        // unmapped, including an odd offset inside the slot span
        add_row(ROW_RD, 12'h040, 32'd0, 4'd0, 1'b0);
        add_row(ROW_RD, 12'h003, 32'd0, 4'd0, 1'b0);
        add_row(ROW_RD, 12'h104, 32'd0, 4'd0, 1'b0);
        add_row(ROW_RD, 12'hffc, 32'd0, 4'd0, 1'b0);
        // slots 2 and 4
        add_row(ROW_RESP, 12'h035, 32'd0, 4'd2, 1'b0);
        add_row(ROW_RESP, 12'h099, 32'd0, 4'd0, 1'b0);
        // slot 7 ids agree but both mask bits are clear
        add_row(ROW_RESP, 12'h000, 32'd0, 4'd0, 1'b0);
        // slots 0, 1, 3 while slot 5 stays masked off
        add_row(ROW_RESP, 12'h012, 32'd0, 4'd3, 1'b0);
        // lands in the middle of the previous burst
        add_row(ROW_RESP, 12'h077, 32'd0, 4'd1, 1'b1);
        for (int i = 0; i < N; i++) begin
            add_row(ROW_DATA, 12'(i), $random(seed), 4'd0, 1'b0);
        end
        for (int i = N - 1; i >= 0; i--) begin
            add_row(ROW_DATA, 12'(i), $random(seed), 4'd0, 1'b0);
        end
    endtask

    // ------------------------------
    // drivers
    // ------------------------------
    task automatic apb_access(input logic write, input logic [11:0] addr, input logic [31:0] data);
        int n;
        paddr   = addr;
        pwdata  = data;
        pwrite  = write;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge ap_clk);
        penable = 1'b1;
        n = 0;
        while (!pready && n < TIMEOUT) begin
            @(negedge ap_clk);
            n++;
        end
        if (!pready) begin
            report_timeout("pready");
        end
        if (!write) begin
            check_value("prdata", model_read(addr), prdata);
        end
        @(negedge ap_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (write) begin
            model_write(addr, data);
        end
    endtask

    task automatic send_response(input row_t r);
        int n;
        int cnt;
        response_in.valid     = 1'b1;
        response_in.bundle_id = r.addr[7:4];
        response_in.lane_id   = r.addr[3:0];
        n = 0;
        while (!response_ready && n < TIMEOUT) begin
            @(negedge ap_clk);
            n++;
        end
        if (!response_ready) begin
            report_timeout("response_ready");
        end
        if (r.hold) begin
            check_value("response stall cycles > 0", 32'd1, 32'(n > 0));
        end
        // ready here, so the coming rising edge takes it
        cnt = predict_matches(r.addr[7:4], r.addr[3:0]);
        check_value("match count", 32'(r.exp_cnt), 32'(cnt));
        if (cnt > 0) begin
            burst_cyc = cyc + 1;
        end
        @(negedge ap_clk);
        response_in.valid = 1'b0;
    endtask

    task automatic send_data(input row_t r);
        int          n;
        result_exp_t e;
        n = 0;
        // config has to reach the kernels first
        while ((busy_pulse || exp_deliv.size() != 0) && n < TIMEOUT) begin
            @(negedge ap_clk);
            n++;
        end
        if (busy_pulse || exp_deliv.size() != 0) begin
            report_timeout("config deliveries");
        end
        data_in.valid   = 1'b1;
        data_in.kernel  = r.addr[2:0];
        data_in.operand = r.data;
        e.kernel = r.addr[2:0];
        e.value  = kernel_calc(k_op[r.addr[2:0]], r.data, k_param[r.addr[2:0]]);
        e.due    = cyc + 2;
        exp_res.push_back(e);
    endtask

    // ------------------------------
    // output monitors
    // ------------------------------
    always @(negedge ap_clk) begin
        deliv_exp_t  d;
        result_exp_t e;
        logic        exp_valid;
        if (!areset) begin
            exp_valid = more_due || (cyc == burst_cyc);
            check_value("delivery_out.valid", 32'(exp_valid), 32'(delivery_out.valid));
            check_value("busy_pulse", 32'(exp_valid), 32'(busy_pulse));
            if (exp_valid) begin
                check_value("response_ready", 32'd0, 32'(response_ready));
            end
            more_due = 1'b0;
            if (delivery_out.valid && exp_deliv.size() != 0) begin
                d = exp_deliv.pop_front();
                check_value("delivery_out.slot", 32'(d.slot), 32'(delivery_out.slot));
                check_value("delivery_out.param", d.param, delivery_out.param);
                check_value("delivery_out.op", 32'(d.op), 32'(delivery_out.op));
                // kernel takes the slot on this rising edge
                k_param[d.slot] = d.param;
                k_op[d.slot]    = d.op;
                more_due        = !d.last;
            end
            if (result_out.valid) begin
                check_value("results outstanding", 32'd1, 32'(exp_res.size() != 0));
            end
            if (result_out.valid && exp_res.size() != 0) begin
                e = exp_res.pop_front();
                check_value("result_out.kernel", 32'(e.kernel), 32'(result_out.kernel));
                check_value("result_out.value", e.value, result_out.value);
                check_value("result cycle", e.due, cyc);
            end
        end
    end

    initial begin
        int n;
        seed        = 32'h5e317272;
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        more_due    = 1'b0;
        ap_clk      = 1'b0;
        areset      = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        response_in = '0;
        data_in     = '0;
        m_cast      = '0;
        m_lane      = '0;
        cfg_param = '{32'h0000_0100, 32'h0000_0033, 32'h8000_0000, 32'h8000_0000,
                      32'h4000_0000, 32'h1234_5678, 32'h0000_0007, 32'h0bad_f00d};
        // {bundle, lane, op}
        cfg_meta  = '{10'h048, 10'h049, 10'h0d6, 10'h04b, 10'h0d7, 10'h048, 10'h1dd, 10'h000};
        for (int i = 0; i < N; i++) begin
            m_param[i] = '0;
            m_meta[i]  = '0;
            k_param[i] = '0;
            k_op[i]    = glay_cfg_pkg::OP_ADD;
        end
        build_rows();
        repeat (16) @(posedge ap_clk);
        @(negedge ap_clk);
        areset = 1'b0;
        check_value("response_ready", 32'd1, 32'(response_ready));
        check_value("result_out.valid", 32'd0, 32'(result_out.valid));
        foreach (rows[i]) begin
            @(negedge ap_clk);
            if (rows[i].kind != ROW_DATA) begin
                data_in.valid = 1'b0;
            end
            case (rows[i].kind)
                ROW_WR:   apb_access(1'b1, rows[i].addr, rows[i].data);
                ROW_RD:   apb_access(1'b0, rows[i].addr, rows[i].data);
                ROW_RESP: send_response(rows[i]);
                default:  send_data(rows[i]);
            endcase
        end
        @(negedge ap_clk);
        data_in.valid = 1'b0;
        n = 0;
        while ((exp_deliv.size() != 0 || exp_res.size() != 0) && n < TIMEOUT) begin
            @(negedge ap_clk);
            n++;
        end
        if (exp_deliv.size() != 0 || exp_res.size() != 0) begin
            report_timeout("outstanding deliveries and results");
        end
        // quiet tail, any stray output trips the monitor
        repeat (4) @(negedge ap_clk);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
